/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_controller
FILELIST = build.f
PASS_MSG = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/main_decoder.sv
hdl/branch_resolver.sv
hdl/ctrl_pipeline.sv
hdl/controller.sv
tb/tb_controller.sv

/* hdl/branch_resolver.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module branch_resolver (
    input  ctrl_pkg::instr_word_u instr,
    input  ctrl_pkg::branch_cmp_t cmp,
    output ctrl_pkg::flow_ctrl_t  flow
);

    logic taken;

    always_comb
    begin
        flow = '0;
        case (instr.i.op)
            `OP_BEQ:
            begin
                flow.isbranch    = 1'b1;
                flow.branch_kind = ctrl_pkg::br_beq;
            end
            `OP_BNE:
            begin
                flow.isbranch    = 1'b1;
                flow.branch_kind = ctrl_pkg::br_bne;
            end
            `OP_BLEZ:
            begin
                flow.isbranch    = 1'b1;
                flow.branch_kind = ctrl_pkg::br_blez;
            end
            `OP_BGTZ:
            begin
                flow.isbranch    = 1'b1;
                flow.branch_kind = ctrl_pkg::br_bgtz;
            end
            `OP_REGIMM:
            begin
                flow.isbranch = 1'b1;
                case (instr.i.rt)
                    `RI_BLTZ:   flow.branch_kind = ctrl_pkg::br_bltz;
                    `RI_BGEZ:   flow.branch_kind = ctrl_pkg::br_bgez;
                    `RI_BLTZAL: flow.branch_kind = ctrl_pkg::br_bltzal;
                    `RI_BGEZAL: flow.branch_kind = ctrl_pkg::br_bgezal;
                    default:    flow.isbranch = 1'b0;
                endcase
            end
            `OP_J:
            begin
                flow.isjump    = 1'b1;
                flow.jump_kind = ctrl_pkg::jmp_j;
            end
            `OP_JAL:
            begin
                flow.isjump    = 1'b1;
                flow.jump_kind = ctrl_pkg::jmp_jal;
            end
            `OP_SPECIAL:
            begin
                if (instr.r.funct == `FN_JR)
                begin
                    flow.isjump    = 1'b1;
                    flow.jump_kind = ctrl_pkg::jmp_jr;
                end
                else if (instr.r.funct == `FN_JALR)
                begin
                    flow.isjump    = 1'b1;
                    flow.jump_kind = ctrl_pkg::jmp_jalr;
                end
            end
            default: ;
        endcase

        taken = 1'b0;
        case (flow.branch_kind)
            ctrl_pkg::br_beq:    taken = cmp.equal;
            ctrl_pkg::br_bne:    taken = !cmp.equal;
            ctrl_pkg::br_bgez,
            ctrl_pkg::br_bgezal: taken = cmp.g0 || cmp.e0;
            ctrl_pkg::br_bgtz:   taken = cmp.g0;
            ctrl_pkg::br_blez:   taken = !cmp.g0;
            ctrl_pkg::br_bltz,
            ctrl_pkg::br_bltzal: taken = !cmp.g0 && !cmp.e0;   // Strictly negative
            default:             taken = 1'b0;
        endcase
        flow.pcsrc = flow.isbranch && taken;
    end

endmodule

/* hdl/controller.sv */
`timescale 1ns/1ps

module controller (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::instr_word_u dinstr,
    input  ctrl_pkg::branch_cmp_t dcompare,
    input  ctrl_pkg::stage_bits_t stall,
    input  ctrl_pkg::stage_bits_t flush,
    output ctrl_pkg::ctrl_reg_t   dstage,
    output ctrl_pkg::ctrl_reg_t   estage,
    output ctrl_pkg::ctrl_reg_t   mstage,
    output ctrl_pkg::ctrl_reg_t   wstage
);

    ctrl_pkg::dp_ctrl_t   dec_dp;
    ctrl_pkg::flow_ctrl_t dec_flow;

    main_decoder i_main_decoder (
        .instr (dinstr),
        .dp    (dec_dp)
    );

    branch_resolver i_branch_resolver (
        .instr (dinstr),
        .cmp   (dcompare),
        .flow  (dec_flow)
    );

    ctrl_pipeline i_ctrl_pipeline (
        .clk    (clk),
        .reset  (reset),
        .dp     (dec_dp),
        .flow   (dec_flow),
        .stall  (stall),
        .flush  (flush),
        .dstage (dstage),
        .estage (estage),
        .mstage (mstage),
        .wstage (wstage)
    );

endmodule

/* hdl/ctrl_consts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

`define OP_W        6
`define FUNCT_W     6
`define REGF_W      5
`define INSTR_W     32
`define PIPE_STAGES 3

`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000   // Not supported
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_SYSCALL  6'b001100   // Not supported
`define FN_MULT     6'b011000   // Not supported
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`define RI_BLTZ     5'b00000
`define RI_BGEZ     5'b00001
`define RI_BLTZAL   5'b10000
`define RI_BGEZAL   5'b10001

`endif

/* hdl/ctrl_pipeline.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module ctrl_pipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  ctrl_pkg::dp_ctrl_t    dp,
    input  ctrl_pkg::flow_ctrl_t  flow,
    input  ctrl_pkg::stage_bits_t stall,
    input  ctrl_pkg::stage_bits_t flush,
    output ctrl_pkg::ctrl_reg_t   dstage,
    output ctrl_pkg::ctrl_reg_t   estage,
    output ctrl_pkg::ctrl_reg_t   mstage,
    output ctrl_pkg::ctrl_reg_t   wstage
);

    ctrl_pkg::ctrl_reg_t     stage_d [`PIPE_STAGES];
    ctrl_pkg::ctrl_reg_t     stage_q [`PIPE_STAGES];
    logic [`PIPE_STAGES-1:0] stall_v;
    logic [`PIPE_STAGES-1:0] flush_v;

    assign dstage.dp   = dp;
    assign dstage.flow = flow;

    // Bit 0 is E, bit 2 is W
    assign stall_v = {stall.w, stall.m, stall.e};
    assign flush_v = {flush.w, flush.m, flush.e};

    assign stage_d[0] = dstage;
    assign stage_d[1] = stage_q[0];
    assign stage_d[2] = stage_q[1];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `PIPE_STAGES; i++)
        begin
            if (reset || flush_v[i])   // Flush beats stall
                stage_q[i] <= '0;
            else if (!stall_v[i])
                stage_q[i] <= stage_d[i];
        end
    end

    assign estage = stage_q[0];
    assign mstage = stage_q[1];
    assign wstage = stage_q[2];

endmodule

/* hdl/ctrl_pkg.sv */
`include "ctrl_consts.svh"

package ctrl_pkg;

    typedef struct packed {
        logic [`OP_W-1:0]    op;
        logic [`REGF_W-1:0]  rs;
        logic [`REGF_W-1:0]  rt;
        logic [`REGF_W-1:0]  rd;
        logic [`REGF_W-1:0]  shamt;
        logic [`FUNCT_W-1:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [`OP_W-1:0]                    op;
        logic [`REGF_W-1:0]                  rs;
        logic [`REGF_W-1:0]                  rt;   // REGIMM selector
        logic [`INSTR_W-`OP_W-2*`REGF_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor, alu_or, alu_xor
    } alu_func_e;

    typedef enum logic [1:0] {sft_lui, sft_sll, sft_sra, sft_srl} sft_func_e;
    typedef enum logic {out_alu, out_sft} out_sel_e;
    typedef enum logic [1:0] {regdst_rt, regdst_rd, regdst_ra} regdst_e;
    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz, br_bgezal, br_bltzal
    } branch_kind_e;

    typedef enum logic [1:0] {jmp_j, jmp_jr, jmp_jal, jmp_jalr} jump_kind_e;

    typedef struct packed {
        alu_func_e alu_func;
        sft_func_e sft_func;
        out_sel_e  out_sel;
        logic      alu_srcb_sel_rt;
        logic      sft_srcb_sel_rs;
        logic      sft_srca_sel_imm;
        logic      regwrite;
        regdst_e   regdst;
        logic      imm_sign;
        logic      intovf_en;
        logic      memreq;
        logic      memwr;
        mem_size_e size;
        logic      rdata_sign;
        logic      memtoreg;
        logic      reserved_instr;
    } dp_ctrl_t;

    typedef struct packed {
        logic         isbranch;
        branch_kind_e branch_kind;
        logic         isjump;
        jump_kind_e   jump_kind;
        logic         pcsrc;
    } flow_ctrl_t;

    typedef struct packed {
        dp_ctrl_t   dp;
        flow_ctrl_t flow;
    } ctrl_reg_t;

    typedef struct packed {
        logic equal;   // rs == rt
        logic g0;      // rs > 0
        logic e0;      // rs == 0
    } branch_cmp_t;

    typedef struct packed {
        logic e;
        logic m;
        logic w;
    } stage_bits_t;

endpackage

/* hdl/main_decoder.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module main_decoder (
    input  ctrl_pkg::instr_word_u instr,
    output ctrl_pkg::dp_ctrl_t    dp
);

    logic rsvd;
    logic shift;

    always_comb
    begin
        dp    = '0;
        rsvd  = 1'b0;
        shift = 1'b0;
        case (instr.r.op)
            `OP_SPECIAL:
            begin
                dp.regwrite        = 1'b1;
                dp.regdst          = ctrl_pkg::regdst_rd;
                dp.alu_srcb_sel_rt = 1'b1;
                case (instr.r.funct)
                    `FN_ADD, `FN_ADDU:
                        dp.alu_func = ctrl_pkg::alu_add;
                    `FN_SUB, `FN_SUBU:
                        dp.alu_func = ctrl_pkg::alu_sub;
                    `FN_SLT:  dp.alu_func = ctrl_pkg::alu_slt;
                    `FN_SLTU: dp.alu_func = ctrl_pkg::alu_sltu;
                    `FN_AND:  dp.alu_func = ctrl_pkg::alu_and;
                    `FN_NOR:  dp.alu_func = ctrl_pkg::alu_nor;
                    `FN_OR:   dp.alu_func = ctrl_pkg::alu_or;
                    `FN_XOR:  dp.alu_func = ctrl_pkg::alu_xor;
                    `FN_SLL, `FN_SLLV:
                    begin
                        shift       = 1'b1;
                        dp.sft_func = ctrl_pkg::sft_sll;
                    end
                    `FN_SRL, `FN_SRLV:
                    begin
                        shift       = 1'b1;
                        dp.sft_func = ctrl_pkg::sft_srl;
                    end
                    `FN_SRA, `FN_SRAV:
                    begin
                        shift       = 1'b1;
                        dp.sft_func = ctrl_pkg::sft_sra;
                    end
                    `FN_JR:
                    begin
                        dp.regwrite        = 1'b0;
                        dp.alu_srcb_sel_rt = 1'b0;
                    end
                    `FN_JALR:
                        dp.alu_srcb_sel_rt = 1'b0;   // Link goes to rd
                    default:
                        rsvd = 1'b1;
                endcase
                dp.intovf_en = (instr.r.funct == `FN_ADD) || (instr.r.funct == `FN_SUB);
            end
            `OP_ADDI, `OP_ADDIU:
            begin
                dp.regwrite  = 1'b1;
                dp.imm_sign  = 1'b1;
                dp.intovf_en = !instr.i.op[0];   // ADDI only
            end
            `OP_SLTI, `OP_SLTIU:
            begin
                dp.regwrite = 1'b1;
                dp.imm_sign = 1'b1;
                dp.alu_func = instr.i.op[0] ? ctrl_pkg::alu_sltu : ctrl_pkg::alu_slt;
            end
            `OP_ANDI:
            begin
                dp.regwrite = 1'b1;
                dp.alu_func = ctrl_pkg::alu_and;
            end
            `OP_ORI:
            begin
                dp.regwrite = 1'b1;
                dp.alu_func = ctrl_pkg::alu_or;
            end
            `OP_XORI:
            begin
                dp.regwrite = 1'b1;
                dp.alu_func = ctrl_pkg::alu_xor;
            end
            `OP_LUI:
            begin
                dp.regwrite         = 1'b1;
                dp.out_sel          = ctrl_pkg::out_sft;
                dp.sft_srca_sel_imm = 1'b1;
            end
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW:
            begin
                dp.regwrite   = 1'b1;
                dp.memreq     = 1'b1;
                dp.memtoreg   = 1'b1;
                dp.imm_sign   = 1'b1;
                dp.rdata_sign = !instr.i.op[2];   // Clear for LBU and LHU
            end
            `OP_SB, `OP_SH, `OP_SW:
            begin
                dp.memreq   = 1'b1;
                dp.memwr    = 1'b1;
                dp.imm_sign = 1'b1;
            end
            `OP_REGIMM:
            begin
                case (instr.i.rt)
                    `RI_BLTZAL, `RI_BGEZAL:
                    begin
                        dp.regwrite = 1'b1;
                        dp.regdst   = ctrl_pkg::regdst_ra;
                    end
                    `RI_BLTZ, `RI_BGEZ: ;
                    default:
                        rsvd = 1'b1;
                endcase
            end
            `OP_JAL:
            begin
                dp.regwrite = 1'b1;
                dp.regdst   = ctrl_pkg::regdst_ra;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J: ;
            default:
                rsvd = 1'b1;
        endcase

        // Access width from the low opcode bits
        if (dp.memreq)
            dp.size = instr.i.op[1] ? ctrl_pkg::size_word
                    : (instr.i.op[0] ? ctrl_pkg::size_half : ctrl_pkg::size_byte);

        if (shift)
        begin
            dp.out_sel         = ctrl_pkg::out_sft;
            dp.alu_srcb_sel_rt = 1'b0;
            dp.sft_srcb_sel_rs = instr.r.funct[2];   // Variable forms
        end

        if (rsvd)
        begin
            dp                = '0;
            dp.reserved_instr = 1'b1;
        end
    end

endmodule

/* tb/tb_controller.sv */
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module tb_controller;

    localparam int num_vectors  = 3000;
    localparam int reset_cycles = 5;
    localparam int timeout_ns   = (num_vectors + reset_cycles) * 4 + 200;
    localparam int n_mnem       = 50;

    // Upper six bits are the opcode, lower six the funct or REGIMM rt
    localparam logic [11:0] mnem_table [n_mnem] = '{
        {`OP_SPECIAL, `FN_ADD},   {`OP_SPECIAL, `FN_ADDU},  {`OP_SPECIAL, `FN_SUB},
        {`OP_SPECIAL, `FN_SUBU},  {`OP_SPECIAL, `FN_SLT},   {`OP_SPECIAL, `FN_SLTU},
        {`OP_SPECIAL, `FN_AND},   {`OP_SPECIAL, `FN_OR},    {`OP_SPECIAL, `FN_XOR},
        {`OP_SPECIAL, `FN_NOR},   {`OP_SPECIAL, `FN_SLL},   {`OP_SPECIAL, `FN_SRL},
        {`OP_SPECIAL, `FN_SRA},   {`OP_SPECIAL, `FN_SLLV},  {`OP_SPECIAL, `FN_SRLV},
        {`OP_SPECIAL, `FN_SRAV},  {`OP_SPECIAL, `FN_JR},    {`OP_SPECIAL, `FN_JALR},
        {`OP_ADDI, 6'h00},        {`OP_ADDIU, 6'h00},       {`OP_SLTI, 6'h00},
        {`OP_SLTIU, 6'h00},       {`OP_ANDI, 6'h00},        {`OP_ORI, 6'h00},
        {`OP_XORI, 6'h00},        {`OP_LUI, 6'h00},         {`OP_LB, 6'h00},
        {`OP_LBU, 6'h00},         {`OP_LH, 6'h00},          {`OP_LHU, 6'h00},
        {`OP_LW, 6'h00},          {`OP_SB, 6'h00},          {`OP_SH, 6'h00},
        {`OP_SW, 6'h00},          {`OP_BEQ, 6'h00},         {`OP_BNE, 6'h00},
        {`OP_BLEZ, 6'h00},        {`OP_BGTZ, 6'h00},        {`OP_J, 6'h00},
        {`OP_JAL, 6'h00},         {`OP_REGIMM, 1'b0, `RI_BLTZ},
        {`OP_REGIMM, 1'b0, `RI_BGEZ},                       {`OP_REGIMM, 1'b0, `RI_BLTZAL},
        {`OP_REGIMM, 1'b0, `RI_BGEZAL},                     {`OP_SPECIAL, `FN_MULT},
        {`OP_SPECIAL, `FN_SYSCALL},                         {`OP_SPECIAL, 6'b001101},
        {`OP_SPECIAL, 6'b010000}, {`OP_COP0, 6'h00},        {6'b011100, 6'h02}
    };

    logic                  clk = 1'b0;
    logic                  reset;
    ctrl_pkg::instr_word_u dinstr;
    ctrl_pkg::branch_cmp_t dcompare;
    ctrl_pkg::stage_bits_t stall;
    ctrl_pkg::stage_bits_t flush;
    ctrl_pkg::ctrl_reg_t   dstage;
    ctrl_pkg::ctrl_reg_t   estage;
    ctrl_pkg::ctrl_reg_t   mstage;
    ctrl_pkg::ctrl_reg_t   wstage;

    ctrl_pkg::ctrl_reg_t exp_d;
    ctrl_pkg::ctrl_reg_t exp_e;
    ctrl_pkg::ctrl_reg_t exp_m;
    ctrl_pkg::ctrl_reg_t exp_w;
    logic [31:0]         lfsr;
    int                  errors;
    int                  checks;

    controller i_controller (
        .clk      (clk),
        .reset    (reset),
        .dinstr   (dinstr),
        .dcompare (dcompare),
        .stall    (stall),
        .flush    (flush),
        .dstage   (dstage),
        .estage   (estage),
        .mstage   (mstage),
        .wstage   (wstage)
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    // One LFSR step per bit, newest bit in the LSB
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic branch_taken(input ctrl_pkg::branch_kind_e kind,
                                          input ctrl_pkg::branch_cmp_t  c);
        case (kind)
            ctrl_pkg::br_beq:    return c.equal;
            ctrl_pkg::br_bne:    return !c.equal;
            ctrl_pkg::br_bgez,
            ctrl_pkg::br_bgezal: return c.g0 || c.e0;
            ctrl_pkg::br_bgtz:   return c.g0;
            ctrl_pkg::br_blez:   return !c.g0;
            default:             return !c.g0 && !c.e0;   // bltz, bltzal
        endcase
    endfunction

    function automatic ctrl_pkg::ctrl_reg_t expected_decode(input logic [31:0]           w,
                                                            input ctrl_pkg::branch_cmp_t c);
        ctrl_pkg::ctrl_reg_t x;
        logic [5:0]          op;
        logic [5:0]          fn;
        logic [4:0]          rt;
        logic                bad;
        logic                shift;
        logic                jump;
        x   = '0;
        op  = w[31:26];
        fn  = w[5:0];
        rt  = w[20:16];
        bad = 1'b0;
        case (op)
            `OP_SPECIAL:
            begin
                case (fn)
                    `FN_ADD, `FN_ADDU: x.dp.alu_func = ctrl_pkg::alu_add;
                    `FN_SUB, `FN_SUBU: x.dp.alu_func = ctrl_pkg::alu_sub;
                    `FN_SLT:           x.dp.alu_func = ctrl_pkg::alu_slt;
                    `FN_SLTU:          x.dp.alu_func = ctrl_pkg::alu_sltu;
                    `FN_AND:           x.dp.alu_func = ctrl_pkg::alu_and;
                    `FN_OR:            x.dp.alu_func = ctrl_pkg::alu_or;
                    `FN_XOR:           x.dp.alu_func = ctrl_pkg::alu_xor;
                    `FN_NOR:           x.dp.alu_func = ctrl_pkg::alu_nor;
                    `FN_SLL, `FN_SLLV: x.dp.sft_func = ctrl_pkg::sft_sll;
                    `FN_SRL, `FN_SRLV: x.dp.sft_func = ctrl_pkg::sft_srl;
                    `FN_SRA, `FN_SRAV: x.dp.sft_func = ctrl_pkg::sft_sra;
                    `FN_JR:            x.flow.jump_kind = ctrl_pkg::jmp_jr;
                    `FN_JALR:          x.flow.jump_kind = ctrl_pkg::jmp_jalr;
                    default:           bad = 1'b1;
                endcase
                shift = fn inside {`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV};
                jump  = (fn == `FN_JR) || (fn == `FN_JALR);
                x.flow.isjump        = jump;
                x.dp.regwrite        = (fn != `FN_JR);
                x.dp.regdst          = ctrl_pkg::regdst_rd;
                x.dp.out_sel         = shift ? ctrl_pkg::out_sft : ctrl_pkg::out_alu;
                x.dp.alu_srcb_sel_rt = !shift && !jump;
                x.dp.sft_srcb_sel_rs = fn inside {`FN_SLLV, `FN_SRLV, `FN_SRAV};
                x.dp.intovf_en       = (fn == `FN_ADD) || (fn == `FN_SUB);
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
            begin
                x.dp.regwrite  = 1'b1;
                x.dp.imm_sign  = op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
                x.dp.intovf_en = (op == `OP_ADDI);
                case (op)
                    `OP_SLTI:  x.dp.alu_func = ctrl_pkg::alu_slt;
                    `OP_SLTIU: x.dp.alu_func = ctrl_pkg::alu_sltu;
                    `OP_ANDI:  x.dp.alu_func = ctrl_pkg::alu_and;
                    `OP_ORI:   x.dp.alu_func = ctrl_pkg::alu_or;
                    `OP_XORI:  x.dp.alu_func = ctrl_pkg::alu_xor;
                    `OP_LUI:
                    begin
                        x.dp.out_sel          = ctrl_pkg::out_sft;
                        x.dp.sft_func         = ctrl_pkg::sft_lui;
                        x.dp.sft_srca_sel_imm = 1'b1;
                    end
                    default:   x.dp.alu_func = ctrl_pkg::alu_add;
                endcase
            end
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW:
            begin
                x.dp.memreq     = 1'b1;
                x.dp.imm_sign   = 1'b1;
                x.dp.memwr      = op inside {`OP_SB, `OP_SH, `OP_SW};
                x.dp.regwrite   = !x.dp.memwr;
                x.dp.memtoreg   = !x.dp.memwr;
                x.dp.rdata_sign = op inside {`OP_LB, `OP_LH, `OP_LW};
                if (op inside {`OP_LW, `OP_SW})
                    x.dp.size = ctrl_pkg::size_word;
                else if (op inside {`OP_LH, `OP_LHU, `OP_SH})
                    x.dp.size = ctrl_pkg::size_half;
                else
                    x.dp.size = ctrl_pkg::size_byte;
            end
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ:
            begin
                x.flow.isbranch = 1'b1;
                case (op)
                    `OP_BEQ:  x.flow.branch_kind = ctrl_pkg::br_beq;
                    `OP_BNE:  x.flow.branch_kind = ctrl_pkg::br_bne;
                    `OP_BLEZ: x.flow.branch_kind = ctrl_pkg::br_blez;
                    default:  x.flow.branch_kind = ctrl_pkg::br_bgtz;
                endcase
            end
            `OP_REGIMM:
            begin
                x.flow.isbranch = 1'b1;
                case (rt)
                    `RI_BLTZ:   x.flow.branch_kind = ctrl_pkg::br_bltz;
                    `RI_BGEZ:   x.flow.branch_kind = ctrl_pkg::br_bgez;
                    `RI_BLTZAL: x.flow.branch_kind = ctrl_pkg::br_bltzal;
                    `RI_BGEZAL: x.flow.branch_kind = ctrl_pkg::br_bgezal;
                    default:    bad = 1'b1;
                endcase
                if (rt == `RI_BLTZAL || rt == `RI_BGEZAL)
                begin
                    x.dp.regwrite = 1'b1;
                    x.dp.regdst   = ctrl_pkg::regdst_ra;
                end
            end
            `OP_J, `OP_JAL:
            begin
                x.flow.isjump    = 1'b1;
                x.flow.jump_kind = (op == `OP_JAL) ? ctrl_pkg::jmp_jal : ctrl_pkg::jmp_j;
                x.dp.regwrite    = (op == `OP_JAL);
                x.dp.regdst      = (op == `OP_JAL) ? ctrl_pkg::regdst_ra : ctrl_pkg::regdst_rt;
            end
            default:
                bad = 1'b1;
        endcase
        if (x.flow.isbranch)
            x.flow.pcsrc = branch_taken(x.flow.branch_kind, c);
        if (bad)
        begin
            x                   = '0;
            x.dp.reserved_instr = 1'b1;
        end
        return x;
    endfunction

    task automatic drive_inputs();
        logic [31:0] w;
        logic [31:0] r;
        logic [11:0] ent;
        w = rand_bits(32);
        r = rand_bits(3);
        if (r != 0)   // One word in eight stays fully random
        begin
            r        = rand_bits(6) % n_mnem;
            ent      = mnem_table[r[5:0]];
            w[31:26] = ent[11:6];
            if (ent[11:6] == `OP_SPECIAL)
                w[5:0] = ent[5:0];
            else if (ent[11:6] == `OP_REGIMM)
                w[20:16] = ent[4:0];
        end
        dinstr   = w;
        r        = rand_bits(3);
        dcompare = r[2:0];
        stall.e  = (rand_bits(4) == 0);
        stall.m  = (rand_bits(4) == 0);
        stall.w  = (rand_bits(4) == 0);
        flush.e  = (rand_bits(4) == 0);
        flush.m  = (rand_bits(4) == 0);
        flush.w  = (rand_bits(4) == 0);
        exp_d    = expected_decode(w, dcompare);
    endtask

    // Mirrors the posedge just past, W first so older entries move on
    task automatic advance_model();
        if (reset || flush.w)
            exp_w = '0;
        else if (!stall.w)
            exp_w = exp_m;
        if (reset || flush.m)
            exp_m = '0;
        else if (!stall.m)
            exp_m = exp_e;
        if (reset || flush.e)
            exp_e = '0;
        else if (!stall.e)
            exp_e = exp_d;
    endtask

    task automatic check_stage(input string name, input ctrl_pkg::ctrl_reg_t act,
                               input ctrl_pkg::ctrl_reg_t exp);
        checks++;
        assert (act == exp)
        else
        begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    initial
    begin
        errors = 0;
        checks = 0;
        lfsr   = 32'd81033;
        reset  = 1'b1;
        exp_e  = '0;
        exp_m  = '0;
        exp_w  = '0;
        drive_inputs();
        for (int cyc = 0; cyc < reset_cycles + num_vectors; cyc++)
        begin
            @(negedge clk);
            advance_model();
            check_stage("dstage", dstage, exp_d);
            check_stage("estage", estage, exp_e);
            check_stage("mstage", mstage, exp_m);
            check_stage("wstage", wstage, exp_w);
            reset = (cyc < reset_cycles - 1);
            drive_inputs();
        end
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #(timeout_ns);
        $display("Run stopped by the watchdog after %0d ns before all vectors were checked",
                 timeout_ns);
        $display("%0d errors in %0d checks", errors, checks);
        $display("Finished with errors");
        $finish;
    end

endmodule
